// File: verilog.f
+incdir+rtl
rtl/cachetest_pkg.sv
rtl/req_if.sv
rtl/req_gen.sv
rtl/req_arbiter.sv
rtl/cache_dm.sv
rtl/cachetest_top.sv
tb/tb_cachetest.sv

// File: Bender.yml
package:
  name: cachetest

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cachetest_pkg.sv
      - rtl/req_if.sv
      - rtl/req_gen.sv
      - rtl/req_arbiter.sv
      - rtl/cache_dm.sv
      - rtl/cachetest_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - tb/tb_cachetest.sv

// File: tb/tb_cachetest.sv
/* Testbench for the cache load: clock and reset, memory model with random
   latency, reference model, response checker and watchdog */

`timescale 1ns/1ns
`include "cachetest_config.svh"

module tb_cachetest;

  localparam int N_RESP    = 400;
  localparam int MIN_SHARE = 80;  // Lowest count per generator
  localparam int LINES     = 1 << `CT_INDEX_BITS;
  localparam int TAG_W     = `CT_ADDR_BITS - `CT_INDEX_BITS;
  localparam int TIMEOUT   = `CT_HOLDOFF + N_RESP * 20;

  logic                    clk;
  logic                    rst;
  logic                    mem_req;
  cachetest_pkg::addr_t    mem_addr;
  logic                    mem_ack;
  cachetest_pkg::data_t    mem_rdata;
  logic                    resp_valid;
  logic                    resp_hit;
  cachetest_pkg::gen_id_t  resp_id;
  cachetest_pkg::addr_t    resp_addr;
  cachetest_pkg::data_t    resp_data;

  logic [31:0]  rng;
  int           cyc;       // Cycles since reset release
  int           n_resp;
  int           n_checks;
  int           errs [6];
  int           per_gen [`CT_NUM_GEN];
  int           next_win [`CT_NUM_GEN];
  int           n_fetch;
  int           n_ack;
  int           n_miss;
  logic         prev_req;

  // Shadow of the cache tags, updated in response order
  logic [TAG_W-1:0]  shadow_tag [LINES];
  logic [LINES-1:0]  shadow_vld;

  cachetest_top uut (
    .clk        (clk),
    .rst        (rst),
    .mem_req    (mem_req),
    .mem_addr   (mem_addr),
    .mem_ack    (mem_ack),
    .mem_rdata  (mem_rdata),
    .resp_valid (resp_valid),
    .resp_hit   (resp_hit),
    .resp_id    (resp_id),
    .resp_addr  (resp_addr),
    .resp_data  (resp_data)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] xorshift();
    logic [31:0] x;
    x   = rng;
    x   = x ^ (x << 13);
    x   = x ^ (x >> 17);
    x   = x ^ (x << 5);
    rng = x;
    return x;
  endfunction

  // Memory contents as a mix of the word address
  function automatic cachetest_pkg::data_t mem_word(input cachetest_pkg::addr_t a);
    logic [31:0] x;
    x = {{(32 - `CT_ADDR_BITS){1'b0}}, a};
    x = (x * 32'h9e3779b1) ^ (x << 17) ^ 32'ha5c30f96;
    return x;
  endfunction

  function automatic cachetest_pkg::addr_t expect_addr(input int id, input int win);
    return cachetest_pkg::addr_t'((id << `CT_WINDOW_BITS) + win);
  endfunction

  function automatic string test_name(input int t);
    case (t)
      0:       return "hold_off";
      1:       return "data";
      2:       return "hit_miss";
      3:       return "addr_order";
      4:       return "fairness";
      default: return "mem_protocol";
    endcase
  endfunction

  task automatic check_data(input int t, input cachetest_pkg::data_t exp,
                            input cachetest_pkg::data_t act);
    n_checks++;
    if (act !== exp) begin
      errs[t]++;
      $display("error %s: expected %h, actual %h", test_name(t), exp, act);
    end
  endtask

  task automatic check_addr(input int t, input cachetest_pkg::addr_t exp,
                            input cachetest_pkg::addr_t act);
    n_checks++;
    if (act !== exp) begin
      errs[t]++;
      $display("error %s: expected %h, actual %h", test_name(t), exp, act);
    end
  endtask

  task automatic check_hit(input int t, input logic exp, input logic act);
    n_checks++;
    if (act !== exp) begin
      errs[t]++;
      $display("error %s: expected %b, actual %b", test_name(t), exp, act);
    end
  endtask

  // Memory answers after 0 to 7 cycles
  initial begin : memory_model
    int delay;
    forever begin
      @(negedge clk);
      mem_ack = 1'b0;
      if (!rst && mem_req) begin
        delay = int'(xorshift() % 8);
        repeat (delay) @(negedge clk);
        mem_ack   = 1'b1;
        mem_rdata = mem_word(mem_addr);
      end
    end
  end

  always @(posedge clk) begin : compare
    int                    idx;
    logic                  exp_hit;
    logic [TAG_W-1:0]      tag;
    if (rst) begin
      cyc = 0;
    end else if (n_resp < N_RESP) begin
      cyc++;
      if (cyc <= `CT_HOLDOFF && (mem_req || resp_valid)) begin
        errs[0]++;
        $display("hold_off: memory request or response in cycle %0d after reset", cyc);
      end
      if (cyc == `CT_HOLDOFF) $display("test %s done, %0d errors", test_name(0), errs[0]);
      if (mem_req && !prev_req) n_fetch++;
      if (mem_req && mem_ack) n_ack++;
      if (mem_ack && !mem_req) begin
        errs[5]++;
        $display("mem_protocol: acknowledge without a pending memory request");
      end
      prev_req = mem_req;
      if (resp_valid) begin
        idx     = int'(resp_addr[`CT_INDEX_BITS-1:0]);
        tag     = resp_addr[`CT_ADDR_BITS-1:`CT_INDEX_BITS];
        exp_hit = shadow_vld[idx] && (shadow_tag[idx] == tag);
        check_data(1, mem_word(resp_addr), resp_data);
        check_hit(2, exp_hit, resp_hit);
        check_addr(3, expect_addr(int'(resp_id), next_win[resp_id]), resp_addr);
        next_win[resp_id] = (next_win[resp_id] + 1) % (1 << `CT_WINDOW_BITS);
        shadow_vld[idx]   = 1'b1;  // Miss fills the line
        shadow_tag[idx]   = tag;
        if (!resp_hit) n_miss++;
        per_gen[resp_id]++;
        n_resp++;
      end
    end
  end

  initial begin : watchdog
    repeat (TIMEOUT + 5) @(posedge clk);
    $display("watchdog: timed out after %0d cycles with %0d of %0d responses",
             TIMEOUT, n_resp, N_RESP);
    $display("TEST FAIL");
    $finish;
  end

  initial begin : main
    int total;
    clk        = 1'b0;
    rst        = 1'b1;
    mem_ack    = 1'b0;
    mem_rdata  = '0;
    rng        = 32'h6dbe735f;
    cyc        = 0;
    n_resp     = 0;
    n_checks   = 0;
    n_fetch    = 0;
    n_ack      = 0;
    n_miss     = 0;
    prev_req   = 1'b0;
    shadow_vld = '0;
    total      = 0;
    for (int t = 0; t < 6; t++) errs[t] = 0;
    for (int g = 0; g < `CT_NUM_GEN; g++) begin
      per_gen[g]  = 0;
      next_win[g] = 0;
    end

    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    wait (n_resp >= N_RESP);
    @(negedge clk);

    for (int g = 0; g < `CT_NUM_GEN; g++) begin
      n_checks++;
      if (per_gen[g] < MIN_SHARE) begin
        errs[4]++;
        $display("fairness: generator %0d completed only %0d responses", g, per_gen[g]);
      end
    end
    n_checks++;
    if (n_fetch != n_ack || n_ack != n_miss) begin
      errs[5]++;
      $display("mem_protocol: %0d fetches, %0d acknowledges and %0d misses do not agree",
               n_fetch, n_ack, n_miss);
    end

    for (int t = 1; t < 6; t++) $display("test %s done, %0d errors", test_name(t), errs[t]);
    for (int t = 0; t < 6; t++) total += errs[t];
    $display("tests: 6, checks: %0d, errors: %0d", n_checks, total);
    if (total == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: rtl/cachetest_top.sv
/* Cache load top level: generator array, arbiter and direct-mapped cache */

`timescale 1ns/1ns
`include "cachetest_config.svh"

module cachetest_top (
  input  logic                    clk,
  input  logic                    rst,
  // Memory port
  output logic                    mem_req,
  output cachetest_pkg::addr_t    mem_addr,
  input  logic                    mem_ack,
  input  cachetest_pkg::data_t    mem_rdata,
  // Response port
  output logic                    resp_valid,
  output logic                    resp_hit,
  output cachetest_pkg::gen_id_t  resp_id,
  output cachetest_pkg::addr_t    resp_addr,
  output cachetest_pkg::data_t    resp_data
);

  req_if gen_req [`CT_NUM_GEN] ();
  req_if cache_req ();  // Arbiter to cache

  for (genvar g = 0; g < `CT_NUM_GEN; g++) begin : g_gen
    req_gen u_gen (
      .clk    (clk),
      .rst    (rst),
      .gen_id (cachetest_pkg::gen_id_t'(g)),
      .req    (gen_req[g])
    );
  end

  req_arbiter u_arb (
    .clk     (clk),
    .rst     (rst),
    .req_in  (gen_req),
    .req_out (cache_req)
  );

  cache_dm u_cache (
    .clk        (clk),
    .rst        (rst),
    .req        (cache_req),
    .mem_req    (mem_req),
    .mem_addr   (mem_addr),
    .mem_ack    (mem_ack),
    .mem_rdata  (mem_rdata),
    .resp_valid (resp_valid),
    .resp_hit   (resp_hit),
    .resp_id    (resp_id),
    .resp_addr  (resp_addr),
    .resp_data  (resp_data)
  );

endmodule

// File: rtl/cache_dm.sv
/* Direct-mapped read-only cache with one-word lines, miss fill over a
   plain memory port and a response pulse per completed read */

`timescale 1ns/1ns
`include "cachetest_config.svh"

module cache_dm (
  input  logic                    clk,
  input  logic                    rst,
  req_if.sink                     req,
  output logic                    mem_req,
  output cachetest_pkg::addr_t    mem_addr,
  input  logic                    mem_ack,
  input  cachetest_pkg::data_t    mem_rdata,
  output logic                    resp_valid,
  output logic                    resp_hit,
  output cachetest_pkg::gen_id_t  resp_id,
  output cachetest_pkg::addr_t    resp_addr,
  output cachetest_pkg::data_t    resp_data
);

  localparam int LINES = 1 << `CT_INDEX_BITS;
  localparam int TAG_W = `CT_ADDR_BITS - `CT_INDEX_BITS;

  cachetest_pkg::cache_state_t  state;

  // Line storage
  logic [TAG_W-1:0]       tag_mem  [LINES];
  cachetest_pkg::data_t   data_mem [LINES];
  logic [LINES-1:0]       line_vld;

  // Request being served
  cachetest_pkg::addr_t    cur_addr;
  cachetest_pkg::gen_id_t  cur_id;
  cachetest_pkg::data_t    cur_data;
  logic                    cur_hit;

  logic [`CT_INDEX_BITS-1:0]  idx;
  logic [TAG_W-1:0]           tag;
  logic                       hit;

  assign idx = cur_addr[`CT_INDEX_BITS-1:0];
  assign tag = cur_addr[`CT_ADDR_BITS-1:`CT_INDEX_BITS];
  assign hit = line_vld[idx] && (tag_mem[idx] == tag);

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= cachetest_pkg::C_IDLE;
      line_vld <= '0;
    end else begin
      case (state)
        cachetest_pkg::C_IDLE: begin
          if (req.valid) state <= cachetest_pkg::C_LOOKUP;
        end
        cachetest_pkg::C_LOOKUP: begin
          state <= hit ? cachetest_pkg::C_RESP : cachetest_pkg::C_FILL;
        end
        cachetest_pkg::C_FILL: begin
          if (mem_ack) begin
            line_vld[idx] <= 1'b1;
            state         <= cachetest_pkg::C_RESP;
          end
        end
        cachetest_pkg::C_RESP: state <= cachetest_pkg::C_IDLE;  // One-cycle pulse
        default:               state <= cachetest_pkg::C_IDLE;
      endcase
    end
  end

  // Payload and arrays
  always_ff @(posedge clk) begin
    if (state == cachetest_pkg::C_IDLE && req.valid) begin
      cur_addr <= req.addr;
      cur_id   <= req.id;
    end
    if (state == cachetest_pkg::C_LOOKUP) begin
      cur_hit  <= hit;
      cur_data <= data_mem[idx];  // Only kept on a hit
    end
    if (state == cachetest_pkg::C_FILL && mem_ack) begin
      tag_mem[idx]  <= tag;
      data_mem[idx] <= mem_rdata;
      cur_data      <= mem_rdata;
    end
  end

  assign req.ready = (state == cachetest_pkg::C_IDLE);

  assign mem_req  = (state == cachetest_pkg::C_FILL);
  assign mem_addr = cur_addr;

  assign resp_valid = (state == cachetest_pkg::C_RESP);
  assign resp_hit   = cur_hit;
  assign resp_id    = cur_id;
  assign resp_addr  = cur_addr;
  assign resp_data  = cur_data;

  // Fetch address held until the memory answers
  a_mem_hold: assert property (
    @(posedge clk) disable iff (rst)
    mem_req && !mem_ack |=> mem_req && $stable(mem_addr)
  );

endmodule

// File: rtl/req_arbiter.sv
/* Round-robin arbiter from the generators to one registered output
   that feeds the cache */

`timescale 1ns/1ns
`include "cachetest_config.svh"

module req_arbiter (
  input  logic  clk,
  input  logic  rst,
  req_if.sink   req_in [`CT_NUM_GEN],
  req_if.source req_out
);

  localparam int N     = `CT_NUM_GEN;
  localparam int PTR_W = (N > 1) ? $clog2(N) : 1;

  logic [N-1:0]            valid_vec;
  logic [N-1:0]            ready_vec;
  cachetest_pkg::addr_t    addr_vec [N];
  cachetest_pkg::gen_id_t  id_vec   [N];

  logic [PTR_W-1:0]        ptr;      // First candidate this cycle
  logic [PTR_W-1:0]        gnt_idx;
  logic                    gnt_found;
  logic                    load_en;
  logic                    take;

  logic                    out_valid;
  cachetest_pkg::addr_t    out_addr;
  cachetest_pkg::gen_id_t  out_id;

  for (genvar g = 0; g < N; g++) begin : g_port
    assign valid_vec[g]    = req_in[g].valid;
    assign addr_vec[g]     = req_in[g].addr;
    assign id_vec[g]       = req_in[g].id;
    assign ready_vec[g]    = take && (gnt_idx == PTR_W'(g));
    assign req_in[g].ready = ready_vec[g];
  end

  // Search starts at the pointer and goes round once
  always_comb begin
    gnt_found = 1'b0;
    gnt_idx   = '0;
    for (int k = 0; k < N; k++) begin
      if (!gnt_found && valid_vec[(int'(ptr) + k) % N]) begin
        gnt_found = 1'b1;
        gnt_idx   = PTR_W'((int'(ptr) + k) % N);
      end
    end
  end

  assign load_en = !out_valid || req_out.ready;  // Empty or draining
  assign take    = load_en && gnt_found;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      ptr       <= '0;
    end else begin
      if (load_en) out_valid <= gnt_found;
      if (take) ptr <= (gnt_idx == PTR_W'(N - 1)) ? '0 : gnt_idx + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      out_addr <= addr_vec[gnt_idx];
      out_id   <= id_vec[gnt_idx];
    end
  end

  assign req_out.valid = out_valid;
  assign req_out.addr  = out_addr;
  assign req_out.id    = out_id;

  // One grant per cycle and only to a generator that is asking
  a_one_grant: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0(ready_vec) && ((ready_vec & ~valid_vec) == '0)
  );

endmodule

// File: rtl/req_gen.sv
/* Read request generator: hold-off after reset, fixed spacing between
   requests and an address walk that wraps inside a private window */

`timescale 1ns/1ns
`include "cachetest_config.svh"

module req_gen (
  input  logic                    clk,
  input  logic                    rst,
  input  cachetest_pkg::gen_id_t  gen_id,
  req_if.source                   req
);

  localparam int HOLD_W = $clog2(`CT_HOLDOFF + 2);
  localparam int PAD_W  = `CT_ADDR_BITS - $bits(cachetest_pkg::gen_id_t) - `CT_WINDOW_BITS;

  cachetest_pkg::gen_state_t   state;
  logic [HOLD_W-1:0]           hold_cnt;
  logic [3:0]                  dist_cnt;
  logic [`CT_WINDOW_BITS-1:0]  win_cnt;  // Position inside the window
  logic                        xfer;

  assign xfer = req.valid && req.ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= cachetest_pkg::GEN_HOLD;
      hold_cnt <= HOLD_W'(`CT_HOLDOFF);
      dist_cnt <= '0;
      win_cnt  <= '0;
    end else begin
      case (state)
        cachetest_pkg::GEN_HOLD: begin
          if (hold_cnt <= HOLD_W'(1)) begin
            state <= cachetest_pkg::GEN_ISSUE;  // Last hold-off cycle
          end else begin
            hold_cnt <= hold_cnt - 1'b1;
          end
        end
        cachetest_pkg::GEN_ISSUE: begin
          if (xfer) begin
            win_cnt <= win_cnt + 1'b1;  // Wraps, so later laps hit
            if (`CT_DISTANCE != 0) begin
              state    <= cachetest_pkg::GEN_GAP;
              dist_cnt <= 4'(`CT_DISTANCE);
            end
          end
        end
        cachetest_pkg::GEN_GAP: begin
          if (dist_cnt <= 4'd1) begin
            state <= cachetest_pkg::GEN_ISSUE;
          end else begin
            dist_cnt <= dist_cnt - 1'b1;
          end
        end
        default: state <= cachetest_pkg::GEN_HOLD;
      endcase
    end
  end

  assign req.valid = (state == cachetest_pkg::GEN_ISSUE);
  assign req.addr  = {{PAD_W{1'b0}}, gen_id, win_cnt};  // Id above window counter
  assign req.id    = gen_id;

  // A pending request may not change or drop before it is taken
  a_req_hold: assert property (
    @(posedge clk) disable iff (rst)
    req.valid && !req.ready |=> req.valid && $stable(req.addr)
  );

endmodule

// File: rtl/req_if.sv
/* Read request channel with valid/ready handshake */

`timescale 1ns/1ns

interface req_if;

  logic                    valid;
  logic                    ready;
  cachetest_pkg::addr_t    addr;
  cachetest_pkg::gen_id_t  id;   // Which generator asked

  // Requester side
  modport source (
    output valid,
    output addr,
    output id,
    input  ready
  );

  // Consumer side
  modport sink (
    input  valid,
    input  addr,
    input  id,
    output ready
  );

endinterface

// File: rtl/cachetest_pkg.sv
/* Shared types for the cache load: address, data and generator id,
   plus the generator and cache state encodings */

`include "cachetest_config.svh"

package cachetest_pkg;

  typedef logic [`CT_ADDR_BITS-1:0] addr_t;  // Word address
  typedef logic [`CT_DATA_BITS-1:0] data_t;
  typedef logic [1:0]               gen_id_t;

  // Request generator
  typedef enum logic [1:0] {
    GEN_HOLD,   // Waiting out the hold-off after reset
    GEN_ISSUE,  // Request on the bus
    GEN_GAP     // Spacing between requests
  } gen_state_t;

  // Cache controller
  typedef enum logic [1:0] {
    C_IDLE,
    C_LOOKUP,
    C_FILL,
    C_RESP
  } cache_state_t;

endpackage

// File: rtl/cachetest_config.svh
/* Build-time settings for the cache load: generator count, pacing,
   address window and cache geometry */

`ifndef CACHETEST_CONFIG_SVH
`define CACHETEST_CONFIG_SVH

// Load side
`define CT_NUM_GEN      4
`define CT_HOLDOFF      80     // Cycles from reset release to first request
`define CT_DISTANCE     1      // Idle cycles after each accepted request, 0..15
`define CT_WINDOW_BITS  3      // 8 words per generator

// Cache side
`define CT_INDEX_BITS   4      // 16 one-word lines
`define CT_ADDR_BITS    12
`define CT_DATA_BITS    32

`endif
